// ==== include/decode_consts.svh ====
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// major opcodes
`define OP_BRANCH   7'b1100011
`define OP_REG      7'b0110011
`define OP_REG32    7'b0111011
`define OP_IMM      7'b0010011
`define OP_IMM32    7'b0011011
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_SYSTEM   7'b1110011

// funct12 of the privileged system calls
`define F12_ECALL   12'h000
`define F12_EBREAK  12'h001

// exception codes
`define EXC_NONE    3'd0
`define EXC_BREAK   3'd1
`define EXC_ECALL   3'd2
`define EXC_FAULT   3'd3
`define EXC_ILLEGAL 3'd4

// instruction queue sizing
`define QUEUE_DEPTH 4
`define QUEUE_PTR_W 2
`define QUEUE_CNT_W 3

`define RESET_PC    64'h0000_0000_8000_0000

// AXI response and protection codes
`define AXI_RESP_OKAY  2'b00
`define AXI_PROT_INSTR 3'b100

`endif

// ==== verilog/decodePkg.sv ====
`default_nettype none

package decodePkg;

    // instruction address
    typedef logic [63:0] addrT;
    typedef logic [31:0] instrT;

    // instruction fields
    typedef logic [6:0]  opcodeT;
    typedef logic [2:0]  funct3T;
    typedef logic [11:0] funct12T;

    typedef logic [1:0]  privT;
    typedef logic [2:0]  exceptT;

    // control bundle fields
    typedef logic [2:0]  branchT;
    typedef logic [1:0]  memModeT;
    typedef logic [2:0]  maskT;
    typedef logic [1:0]  aluOpT;
    typedef logic [1:0]  regSelT;

    // fetch port sequencing
    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_ADDR,
        FETCH_DATA
    } fetchStateT;

endpackage

`default_nettype wire

// ==== verilog/fetchUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module fetchUnit
    import decodePkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstN,
    // AXI4-Lite read address channel
    output logic            arValid,
    input  wire logic       arReady,
    output addrT            arAddr,
    output logic [2:0]      arProt,
    // AXI4-Lite read data channel
    input  wire logic       rValid,
    output logic            rReady,
    input  wire instrT      rData,
    input  wire logic [1:0] rResp,
    // queue write side
    output logic            pushValid,
    input  wire logic       pushReady,
    output instrT           pushInstr,
    output addrT            pushPc,
    output logic            pushFault
);

    fetchStateT state;
    fetchStateT stateNext;
    addrT       pc;
    logic       rXfer;

    // response accepted only while the queue can take it
    assign rXfer = rValid && rReady;

    always_comb begin
        stateNext = state;
        case (state)
            FETCH_IDLE: if (pushReady) stateNext = FETCH_ADDR;
            FETCH_ADDR: if (arReady) stateNext = FETCH_DATA;
            FETCH_DATA: if (rXfer) stateNext = FETCH_ADDR;
            default:    stateNext = FETCH_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= FETCH_IDLE;
            pc    <= `RESET_PC;
        end else begin
            state <= stateNext;
            // sequential fetch only, no redirect
            if (rXfer) pc <= pc + 64'd4;
        end
    end

    assign arValid = (state == FETCH_ADDR);
    assign arAddr  = pc;
    // unprivileged instruction access while an address is offered
    assign arProt  = (state == FETCH_ADDR) ? `AXI_PROT_INSTR : 3'b000;
    assign rReady  = (state == FETCH_DATA) && pushReady;

    // the returned word goes straight into the queue
    assign pushValid = rXfer;
    assign pushInstr = rData;
    assign pushPc    = pc;
    assign pushFault = (rResp != `AXI_RESP_OKAY);

endmodule

`default_nettype wire

// ==== verilog/instrQueue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module instrQueue
    import decodePkg::*;
(
    input  wire logic  clk,
    input  wire logic  rstN,
    input  wire logic  pushValid,
    output logic       pushReady,
    input  wire instrT pushInstr,
    input  wire addrT  pushPc,
    input  wire logic  pushFault,
    output logic       popValid,
    input  wire logic  popReady,
    output instrT      popInstr,
    output addrT       popPc,
    output logic       popFault
);

    instrT instrMem [`QUEUE_DEPTH];
    addrT  pcMem    [`QUEUE_DEPTH];
    logic  faultMem [`QUEUE_DEPTH];

    logic [`QUEUE_PTR_W-1:0] wrPtr;
    logic [`QUEUE_PTR_W-1:0] rdPtr;
    logic [`QUEUE_CNT_W-1:0] count;
    logic                    doPush;
    logic                    doPop;

    assign pushReady = (count != `QUEUE_CNT_W'(`QUEUE_DEPTH));
    assign popValid  = (count != '0);
    assign doPush    = pushValid && pushReady;
    assign doPop     = popValid && popReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == `QUEUE_PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == `QUEUE_PTR_W'(`QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            end
            // simultaneous push and pop keeps the count
            if (doPush && !doPop) count <= count + 1'b1;
            else if (doPop && !doPush) count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            instrMem[wrPtr] <= pushInstr;
            pcMem[wrPtr]    <= pushPc;
            faultMem[wrPtr] <= pushFault;
        end
    end

    // head entry
    assign popInstr = instrMem[rdPtr];
    assign popPc    = pcMem[rdPtr];
    assign popFault = faultMem[rdPtr];

endmodule

`default_nettype wire

// ==== verilog/mainDec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module mainDec
    import decodePkg::*;
(
    input  wire opcodeT  op,
    input  wire funct3T  funct3,
    input  wire funct12T funct12,
    input  wire privT    priv,
    output exceptT       exceptSignal,
    output logic         wArith,
    output regSelT       regSel,
    output logic         aluSrc,
    output logic         memToReg,
    output logic         regWrite,
    output memModeT      memRead,
    output logic         memWrite,
    output maskT         memMask,
    output branchT       branch,
    output aluOpT        aluOp
);

    // wArith | regSel | aluSrc memToReg regWrite | memRead | memWrite | mask | branch | aluOp
    logic [16:0] ctrl;
    exceptT      excCode;
    logic [2:0]  privDiff;
    logic        csrPrivOk;

    // current mode must reach the level held in csr address bits 9:8
    assign privDiff  = {1'b0, priv} - {1'b0, funct12[9:8]};
    assign csrPrivOk = ~privDiff[2];

    always_comb begin
        excCode = `EXC_NONE;
        ctrl    = '0;
        case (op)
            `OP_BRANCH: begin
                ctrl = 17'b0_00_000_00_0_000_000_01;
                case (funct3)
                    3'b000:  ctrl[4:2] = 3'b001;
                    3'b001:  ctrl[4:2] = 3'b011;
                    3'b100:  ctrl[4:2] = 3'b101;
                    3'b101:  ctrl[4:2] = 3'b100;
                    3'b110:  ctrl[4:2] = 3'b110;
                    3'b111:  ctrl[4:2] = 3'b010;
                    default: ctrl[4:2] = 3'b000;
                endcase
            end
            `OP_REG:   ctrl = 17'b0_00_001_00_0_000_000_10;
            `OP_REG32: ctrl = 17'b1_00_001_00_0_000_000_10;
            `OP_IMM:   ctrl = 17'b0_00_101_00_0_000_000_11;
            `OP_IMM32: ctrl = 17'b1_00_101_00_0_000_000_11;
            `OP_LOAD: begin
                ctrl = 17'b0_00_111_00_0_000_000_00;
                // funct3[2] marks the zero-extending loads
                ctrl[10:9] = funct3[2] ? 2'b11 : 2'b01;
                case (funct3[1:0])
                    2'b00:   ctrl[7:5] = 3'b000;
                    2'b01:   ctrl[7:5] = 3'b001;
                    2'b10:   ctrl[7:5] = 3'b011;
                    default: ctrl[7:5] = 3'b111;
                endcase
            end
            `OP_STORE: begin
                ctrl = 17'b0_00_100_00_1_000_000_00;
                case (funct3)
                    3'b000:  ctrl[7:5] = 3'b000;
                    3'b001:  ctrl[7:5] = 3'b001;
                    3'b010:  ctrl[7:5] = 3'b011;
                    default: ctrl[7:5] = 3'b111;
                endcase
            end
            `OP_LUI:   ctrl = 17'b0_01_101_00_0_000_000_00;
            `OP_AUIPC: ctrl = 17'b0_10_101_00_0_000_000_00;
            `OP_JAL,
            `OP_JALR:  ctrl = 17'b0_00_001_00_0_000_111_01;
            `OP_SYSTEM: begin
                if (funct3 == 3'b000) begin
                    if (funct12 == `F12_EBREAK) excCode = `EXC_BREAK;
                    else if (funct12 == `F12_ECALL) excCode = `EXC_ECALL;
                    // wfi, mret, sret not supported yet
                    else excCode = `EXC_ILLEGAL;
                end else if (funct3 == 3'b100) begin
                    excCode = `EXC_ILLEGAL;
                end else if (csrPrivOk) begin
                    // csr read lands in rd
                    ctrl = 17'b0_00_001_00_0_000_000_00;
                end else begin
                    excCode = `EXC_ILLEGAL;
                end
            end
            default: excCode = `EXC_ILLEGAL;
        endcase
    end

    assign exceptSignal = excCode;
    assign wArith       = ctrl[16];
    assign regSel       = ctrl[15:14];
    assign aluSrc       = ctrl[13];
    assign memToReg     = ctrl[12];
    assign regWrite     = ctrl[11];
    assign memRead      = ctrl[10:9];
    assign memWrite     = ctrl[8];
    assign memMask      = ctrl[7:5];
    assign branch       = ctrl[4:2];
    assign aluOp        = ctrl[1:0];

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decodeStage
    import decodePkg::*;
(
    input  wire logic  clk,
    input  wire logic  rstN,
    input  wire logic  popValid,
    output logic       popReady,
    input  wire instrT popInstr,
    input  wire addrT  popPc,
    input  wire logic  popFault,
    input  wire privT  priv,
    output logic       decValid,
    input  wire logic  decReady,
    output addrT       decPc,
    output instrT      decInstr,
    output exceptT     exceptSignal,
    output logic       wArith,
    output regSelT     regSel,
    output logic       aluSrc,
    output logic       memToReg,
    output logic       regWrite,
    output memModeT    memRead,
    output logic       memWrite,
    output maskT       memMask,
    output branchT     branch,
    output aluOpT      aluOp
);

    exceptT  dExcept;
    logic    dWArith;
    regSelT  dRegSel;
    logic    dAluSrc;
    logic    dMemToReg;
    logic    dRegWrite;
    memModeT dMemRead;
    logic    dMemWrite;
    maskT    dMemMask;
    branchT  dBranch;
    aluOpT   dAluOp;
    logic    load;

    mainDec uMainDec (
        .op           (popInstr[6:0]),
        .funct3       (popInstr[14:12]),
        .funct12      (popInstr[31:20]),
        .priv         (priv),
        .exceptSignal (dExcept),
        .wArith       (dWArith),
        .regSel       (dRegSel),
        .aluSrc       (dAluSrc),
        .memToReg     (dMemToReg),
        .regWrite     (dRegWrite),
        .memRead      (dMemRead),
        .memWrite     (dMemWrite),
        .memMask      (dMemMask),
        .branch       (dBranch),
        .aluOp        (dAluOp)
    );

    // register empty or draining this cycle
    assign popReady = !decValid || decReady;
    assign load     = popValid && popReady;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) decValid <= 1'b0;
        else if (popReady) decValid <= popValid;
    end

    always_ff @(posedge clk) begin
        if (load) begin
            decPc    <= popPc;
            decInstr <= popInstr;
            if (popFault) begin
                // bus error replaces whatever the word decodes to
                exceptSignal <= `EXC_FAULT;
                wArith       <= 1'b0;
                regSel       <= '0;
                aluSrc       <= 1'b0;
                memToReg     <= 1'b0;
                regWrite     <= 1'b0;
                memRead      <= '0;
                memWrite     <= 1'b0;
                memMask      <= '0;
                branch       <= '0;
                aluOp        <= '0;
            end else begin
                exceptSignal <= dExcept;
                wArith       <= dWArith;
                regSel       <= dRegSel;
                aluSrc       <= dAluSrc;
                memToReg     <= dMemToReg;
                regWrite     <= dRegWrite;
                memRead      <= dMemRead;
                memWrite     <= dMemWrite;
                memMask      <= dMemMask;
                branch       <= dBranch;
                aluOp        <= dAluOp;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decodeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module decodeTop
    import decodePkg::*;
(
    input  wire logic       clk,
    input  wire logic       rstN,
    output logic            arValid,
    input  wire logic       arReady,
    output addrT            arAddr,
    output logic [2:0]      arProt,
    input  wire logic       rValid,
    output logic            rReady,
    input  wire instrT      rData,
    input  wire logic [1:0] rResp,
    input  wire privT       priv,
    output logic            decValid,
    input  wire logic       decReady,
    output addrT            decPc,
    output instrT           decInstr,
    output exceptT          exceptSignal,
    output logic            wArith,
    output regSelT          regSel,
    output logic            aluSrc,
    output logic            memToReg,
    output logic            regWrite,
    output memModeT         memRead,
    output logic            memWrite,
    output maskT            memMask,
    output branchT          branch,
    output aluOpT           aluOp
);

    // fetch to queue
    logic  pushValid;
    logic  pushReady;
    instrT pushInstr;
    addrT  pushPc;
    logic  pushFault;

    // queue to decode
    logic  popValid;
    logic  popReady;
    instrT popInstr;
    addrT  popPc;
    logic  popFault;

    fetchUnit uFetch (
        .clk       (clk),
        .rstN      (rstN),
        .arValid   (arValid),
        .arReady   (arReady),
        .arAddr    (arAddr),
        .arProt    (arProt),
        .rValid    (rValid),
        .rReady    (rReady),
        .rData     (rData),
        .rResp     (rResp),
        .pushValid (pushValid),
        .pushReady (pushReady),
        .pushInstr (pushInstr),
        .pushPc    (pushPc),
        .pushFault (pushFault)
    );

    instrQueue uQueue (
        .clk       (clk),
        .rstN      (rstN),
        .pushValid (pushValid),
        .pushReady (pushReady),
        .pushInstr (pushInstr),
        .pushPc    (pushPc),
        .pushFault (pushFault),
        .popValid  (popValid),
        .popReady  (popReady),
        .popInstr  (popInstr),
        .popPc     (popPc),
        .popFault  (popFault)
    );

    decodeStage uDecode (
        .clk          (clk),
        .rstN         (rstN),
        .popValid     (popValid),
        .popReady     (popReady),
        .popInstr     (popInstr),
        .popPc        (popPc),
        .popFault     (popFault),
        .priv         (priv),
        .decValid     (decValid),
        .decReady     (decReady),
        .decPc        (decPc),
        .decInstr     (decInstr),
        .exceptSignal (exceptSignal),
        .wArith       (wArith),
        .regSel       (regSel),
        .aluSrc       (aluSrc),
        .memToReg     (memToReg),
        .regWrite     (regWrite),
        .memRead      (memRead),
        .memWrite     (memWrite),
        .memMask      (memMask),
        .branch       (branch),
        .aluOp        (aluOp)
    );

endmodule

`default_nettype wire

// ==== sim/decodeChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module decodeChecker
    import decodePkg::*;
(
    input  wire logic        clk,
    input  wire logic        rstN,
    input  wire logic        arValid,
    input  wire addrT        arAddr,
    input  wire logic [2:0]  arProt,
    input  wire logic        decValid,
    input  wire logic        decReady,
    input  wire addrT        decPc,
    input  wire instrT       decInstr,
    input  wire exceptT      exceptSignal,
    input  wire logic        wArith,
    input  wire regSelT      regSel,
    input  wire logic        aluSrc,
    input  wire logic        memToReg,
    input  wire logic        regWrite,
    input  wire memModeT     memRead,
    input  wire logic        memWrite,
    input  wire maskT        memMask,
    input  wire branchT      branch,
    input  wire aluOpT       aluOp,
    // expected row at the current output index
    input  int               rowTotal,
    input  wire instrT       expInstr,
    input  wire logic [19:0] expCtrl,
    output int               rowIdx,
    output int               errorCount
);

    int   count = 0;
    int   errors = 0;
    logic arSeen = 1'b0;
    logic resetHeld = 1'b0;

    assign rowIdx     = count;
    assign errorCount = errors;

    task automatic compareField(input string name, input logic [63:0] expected,
                                input logic [63:0] actual);
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s expected %0h got %0h",
                     $time, name, expected, actual);
            errors = errors + 1;
        end
    endtask

    task automatic checkRow();
        // pc walks forward by one word per output
        compareField("decPc", `RESET_PC + (64'(count) << 2), decPc);
        compareField("decInstr", 64'(expInstr), 64'(decInstr));
        compareField("exceptSignal", 64'(expCtrl[19:17]), 64'(exceptSignal));
        compareField("wArith", 64'(expCtrl[16]), 64'(wArith));
        compareField("regSel", 64'(expCtrl[15:14]), 64'(regSel));
        compareField("aluSrc", 64'(expCtrl[13]), 64'(aluSrc));
        compareField("memToReg", 64'(expCtrl[12]), 64'(memToReg));
        compareField("regWrite", 64'(expCtrl[11]), 64'(regWrite));
        compareField("memRead", 64'(expCtrl[10:9]), 64'(memRead));
        compareField("memWrite", 64'(expCtrl[8]), 64'(memWrite));
        compareField("memMask", 64'(expCtrl[7:5]), 64'(memMask));
        compareField("branch", 64'(expCtrl[4:2]), 64'(branch));
        compareField("aluOp", 64'(expCtrl[1:0]), 64'(aluOp));
    endtask

    always @(posedge clk) begin
        if (!rstN) begin
            count  <= 0;
            arSeen <= 1'b0;
            // nothing offered once reset has taken hold
            if (resetHeld) begin
                compareField("arValid", 64'd0, 64'(arValid));
                compareField("decValid", 64'd0, 64'(decValid));
            end
            resetHeld <= 1'b1;
        end else begin
            if (arValid) begin
                compareField("arProt", 64'(`AXI_PROT_INSTR), 64'(arProt));
                if (!arSeen) compareField("arAddr", `RESET_PC, arAddr);
                arSeen <= 1'b1;
            end
            if (decValid && decReady) begin
                if (count >= rowTotal) begin
                    $display("Unexpected decode output after the last table row at %0t ns",
                             $time);
                    errors = errors + 1;
                end else begin
                    checkRow();
                end
                count <= count + 1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tbDecodeTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "decode_consts.svh"

module tbDecodeTop
    import decodePkg::*;
();

    localparam int          NUM_ROWS        = 32;
    localparam int          WATCHDOG_CYCLES = NUM_ROWS * 12 + 100;
    localparam logic [31:0] SEED            = 32'h8c19_51de;
    localparam logic [1:0]  OK              = 2'b00;
    localparam logic [1:0]  ERR             = 2'b10;
    localparam privT        USER            = 2'b00;
    localparam privT        MACH            = 2'b11;

    logic       clk;
    logic       rstN;
    logic       arValid;
    logic       arReady;
    addrT       arAddr;
    logic [2:0] arProt;
    logic       rValid;
    logic       rReady;
    instrT      rData;
    logic [1:0] rResp;
    privT       priv;
    logic       decValid;
    logic       decReady;
    addrT       decPc;
    instrT      decInstr;
    exceptT     exceptSignal;
    logic       wArith;
    regSelT     regSel;
    logic       aluSrc;
    logic       memToReg;
    logic       regWrite;
    memModeT    memRead;
    logic       memWrite;
    maskT       memMask;
    branchT     branch;
    aluOpT      aluOp;

    // stimulus table, one row per word address
    instrT       rowWord [NUM_ROWS];
    logic [1:0]  rowResp [NUM_ROWS];
    privT        rowPriv [NUM_ROWS];
    logic [19:0] rowCtrl [NUM_ROWS];
    int          rowCount = 0;

    int          rowIdx;
    int          errorCount;
    instrT       expInstr;
    logic [19:0] expCtrl;
    logic [31:0] axiRng;
    logic [31:0] readyRng;

    decodeTop DUT (
        .clk(clk), .rstN(rstN),
        .arValid(arValid), .arReady(arReady), .arAddr(arAddr), .arProt(arProt),
        .rValid(rValid), .rReady(rReady), .rData(rData), .rResp(rResp),
        .priv(priv), .decValid(decValid), .decReady(decReady),
        .decPc(decPc), .decInstr(decInstr), .exceptSignal(exceptSignal),
        .wArith(wArith), .regSel(regSel), .aluSrc(aluSrc), .memToReg(memToReg),
        .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
        .memMask(memMask), .branch(branch), .aluOp(aluOp)
    );

    decodeChecker decodeChecker (
        .clk(clk), .rstN(rstN),
        .arValid(arValid), .arAddr(arAddr), .arProt(arProt),
        .decValid(decValid), .decReady(decReady), .decPc(decPc), .decInstr(decInstr),
        .exceptSignal(exceptSignal), .wArith(wArith), .regSel(regSel),
        .aluSrc(aluSrc), .memToReg(memToReg), .regWrite(regWrite),
        .memRead(memRead), .memWrite(memWrite), .memMask(memMask),
        .branch(branch), .aluOp(aluOp),
        .rowTotal(NUM_ROWS), .expInstr(expInstr), .expCtrl(expCtrl),
        .rowIdx(rowIdx), .errorCount(errorCount)
    );

    assign expInstr = (rowIdx < NUM_ROWS) ? rowWord[rowIdx[4:0]] : '0;
    assign expCtrl  = (rowIdx < NUM_ROWS) ? rowCtrl[rowIdx[4:0]] : '0;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // rs1 = x1, rd = x2; only opcode and funct fields matter to the decoder
    function automatic instrT encodeWord(input logic [11:0] f12, input logic [2:0] f3,
                                         input opcodeT op);
        return {f12, 5'd1, f3, 5'd2, op};
    endfunction

    task automatic addRow(input instrT word, input logic [1:0] resp, input privT p,
                          input logic [19:0] ctrl);
        rowWord[rowCount[4:0]] = word;
        rowResp[rowCount[4:0]] = resp;
        rowPriv[rowCount[4:0]] = p;
        rowCtrl[rowCount[4:0]] = ctrl;
        rowCount = rowCount + 1;
    endtask

    task automatic loadTable();
        // ctrl columns: exc wArith regSel aluSrc/memToReg/regWrite memRead memWrite
        // memMask branch aluOp
        // beq bne blt bge bltu bgeu
        addRow(encodeWord(12'h000, 3'b000, `OP_BRANCH), OK, MACH, 20'b000_0_00_000_00_0_000_001_01);
        addRow(encodeWord(12'h000, 3'b001, `OP_BRANCH), OK, MACH, 20'b000_0_00_000_00_0_000_011_01);
        addRow(encodeWord(12'h000, 3'b100, `OP_BRANCH), OK, MACH, 20'b000_0_00_000_00_0_000_101_01);
        addRow(encodeWord(12'h000, 3'b101, `OP_BRANCH), OK, MACH, 20'b000_0_00_000_00_0_000_100_01);
        addRow(encodeWord(12'h000, 3'b110, `OP_BRANCH), OK, MACH, 20'b000_0_00_000_00_0_000_110_01);
        addRow(encodeWord(12'h000, 3'b111, `OP_BRANCH), OK, MACH, 20'b000_0_00_000_00_0_000_010_01);
        // jal, jalr
        addRow(encodeWord(12'h010, 3'b000, `OP_JAL), OK, MACH, 20'b000_0_00_001_00_0_000_111_01);
        addRow(encodeWord(12'h010, 3'b000, `OP_JALR), OK, MACH, 20'b000_0_00_001_00_0_000_111_01);
        // add, addw, addi, addiw
        addRow(encodeWord(12'h003, 3'b000, `OP_REG), OK, MACH, 20'b000_0_00_001_00_0_000_000_10);
        addRow(encodeWord(12'h003, 3'b000, `OP_REG32), OK, MACH, 20'b000_1_00_001_00_0_000_000_10);
        addRow(encodeWord(12'h07f, 3'b000, `OP_IMM), OK, MACH, 20'b000_0_00_101_00_0_000_000_11);
        addRow(encodeWord(12'h07f, 3'b000, `OP_IMM32), OK, MACH, 20'b000_1_00_101_00_0_000_000_11);
        // lb lh lw ld lbu lhu lwu
        addRow(encodeWord(12'h008, 3'b000, `OP_LOAD), OK, MACH, 20'b000_0_00_111_01_0_000_000_00);
        addRow(encodeWord(12'h008, 3'b001, `OP_LOAD), OK, MACH, 20'b000_0_00_111_01_0_001_000_00);
        addRow(encodeWord(12'h008, 3'b010, `OP_LOAD), OK, MACH, 20'b000_0_00_111_01_0_011_000_00);
        addRow(encodeWord(12'h008, 3'b011, `OP_LOAD), OK, MACH, 20'b000_0_00_111_01_0_111_000_00);
        addRow(encodeWord(12'h008, 3'b100, `OP_LOAD), OK, MACH, 20'b000_0_00_111_11_0_000_000_00);
        addRow(encodeWord(12'h008, 3'b101, `OP_LOAD), OK, MACH, 20'b000_0_00_111_11_0_001_000_00);
        addRow(encodeWord(12'h008, 3'b110, `OP_LOAD), OK, MACH, 20'b000_0_00_111_11_0_011_000_00);
        // sb sh sw sd
        addRow(encodeWord(12'h000, 3'b000, `OP_STORE), OK, MACH, 20'b000_0_00_100_00_1_000_000_00);
        addRow(encodeWord(12'h000, 3'b001, `OP_STORE), OK, MACH, 20'b000_0_00_100_00_1_001_000_00);
        addRow(encodeWord(12'h000, 3'b010, `OP_STORE), OK, MACH, 20'b000_0_00_100_00_1_011_000_00);
        addRow(encodeWord(12'h000, 3'b011, `OP_STORE), OK, MACH, 20'b000_0_00_100_00_1_111_000_00);
        // lui, auipc
        addRow(encodeWord(12'h123, 3'b000, `OP_LUI), OK, MACH, 20'b000_0_01_101_00_0_000_000_00);
        addRow(encodeWord(12'h123, 3'b000, `OP_AUIPC), OK, MACH, 20'b000_0_10_101_00_0_000_000_00);
        // ebreak, ecall, csrrs on mstatus from user then machine mode
        addRow(32'h0010_0073, OK, MACH, 20'b001_0_00_000_00_0_000_000_00);
        addRow(32'h0000_0073, OK, MACH, 20'b010_0_00_000_00_0_000_000_00);
        addRow(32'h3000_22f3, OK, USER, 20'b100_0_00_000_00_0_000_000_00);
        addRow(32'h3000_22f3, OK, MACH, 20'b000_0_00_001_00_0_000_000_00);
        // unknown opcode
        addRow(32'h0000_0000, OK, MACH, 20'b100_0_00_000_00_0_000_000_00);
        // bus errors hide the word
        addRow(encodeWord(12'h003, 3'b000, `OP_REG), ERR, MACH, 20'b011_0_00_000_00_0_000_000_00);
        addRow(encodeWord(12'h008, 3'b010, `OP_LOAD), ERR, MACH, 20'b011_0_00_000_00_0_000_000_00);
    endtask

    task automatic waitRandomCycles();
        axiRng = xorshift32(axiRng);
        repeat (axiRng[1:0]) @(negedge clk);
    endtask

    task automatic printCounts();
        $display("Decode outputs checked: %0d of %0d, errors: %0d",
                 rowIdx, NUM_ROWS, errorCount);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory side of the AXI read port
    initial begin : axiResponder
        addrT       offset;
        logic [4:0] row;
        arReady = 1'b0;
        rValid  = 1'b0;
        rData   = '0;
        rResp   = OK;
        axiRng  = SEED;
        wait (rstN === 1'b1);
        forever begin
            @(negedge clk);
            offset = arAddr - `RESET_PC;
            // addresses past the table are never accepted
            if (arValid && offset < addrT'(NUM_ROWS * 4)) begin
                row = offset[6:2];
                waitRandomCycles();
                arReady = 1'b1;
                @(negedge clk);
                arReady = 1'b0;
                waitRandomCycles();
                rValid = 1'b1;
                rData  = rowWord[row];
                rResp  = rowResp[row];
                while (!rReady) @(negedge clk);
                @(negedge clk);
                rValid = 1'b0;
            end
        end
    end

    // downstream ready and the privilege for the row about to load
    initial begin : downstreamDriver
        int nextRow;
        decReady = 1'b0;
        priv     = MACH;
        readyRng = ~SEED;
        forever begin
            @(negedge clk);
            readyRng = xorshift32(readyRng);
            decReady = rstN && readyRng[0];
            nextRow  = rowIdx + int'(decValid);
            if (nextRow < NUM_ROWS) priv = rowPriv[nextRow[4:0]];
        end
    end

    initial begin
        rstN = 1'b0;
        loadTable();
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        wait (rowIdx == NUM_ROWS);
        repeat (4) @(negedge clk);
        printCounts();
        if (errorCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: decode outputs stopped arriving after %0d of %0d rows",
                 rowIdx, NUM_ROWS);
        printCounts();
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+include
verilog/decodePkg.sv
verilog/fetchUnit.sv
verilog/instrQueue.sv
verilog/mainDec.sv
verilog/decodeStage.sv
verilog/decodeTop.sv
sim/decodeChecker.sv
sim/tbDecodeTop.sv

// ==== Makefile ====
# Verilator flow for the decode front end

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f build.f --top-module decodeTop
	verilator --lint-only --timing -f build.f --top-module tbDecodeTop

sim:
	verilator --binary --timing -j 0 -f build.f --top-module tbDecodeTop \
		--Mdir obj_dir -o tbDecodeTop
	./obj_dir/tbDecodeTop > sim.log 2>&1; cat sim.log
	grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
